// ==== Bender.yml ====
package:
  name: sparc_core

sources:
  - hw/sparcPkg.sv
  - hw/ctrlIf.sv
  - hw/registerFile.sv
  - hw/alu.sv
  - hw/controlUnit.sv
  - hw/datapath.sv
  - hw/sparcCore.sv
  - target: test
    files:
      - tb/sparcCoreAssert.sv
      - tb/sparcCoreTb.sv

// ==== files.f ====
hw/sparcPkg.sv
hw/ctrlIf.sv
hw/registerFile.sv
hw/alu.sv
hw/controlUnit.sv
hw/datapath.sv
hw/sparcCore.sv
tb/sparcCoreAssert.sv
tb/sparcCoreTb.sv

// ==== hw/alu.sv ====
`timescale 1ns/1ns

module alu
(
	input logic [5:0] op,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] result,
	output sparcPkg::iccT icc
);

	logic [5:0] baseOp;
	logic [32:0] wide;

	// Flag latching is the datapath's business
	assign baseOp = op & ~(6'd1 << sparcPkg::ccBit);

	always_comb
	begin
		wide = '0;
		result = '0;
		icc.v = 1'b0;
		icc.c = 1'b0;
		case (baseOp)
			sparcPkg::op3Add:
			begin
				wide = {1'b0, a} + {1'b0, b};
				result = wide[31:0];
				icc.c = wide[32];
				icc.v = (a[31] == b[31]) && (result[31] != a[31]);
			end
			sparcPkg::op3Sub:
			begin
				// Carry is the borrow out
				wide = {1'b0, a} - {1'b0, b};
				result = wide[31:0];
				icc.c = wide[32];
				icc.v = (a[31] != b[31]) && (result[31] != a[31]);
			end
			sparcPkg::op3And:
				result = a & b;
			sparcPkg::op3Or:
				result = a | b;
			sparcPkg::op3Xor:
				result = a ^ b;
			default:
				result = '0;
		endcase
		icc.n = result[31];
		icc.z = (result == 32'd0);
	end

endmodule

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit
(
	input logic Clk,
	input logic RESET,
	ctrlIf.ctrl bus,
	input logic memMfc,
	output logic memEnable,
	output logic retireValid,
	output logic retireIllegal
);

	typedef enum logic [3:0] {
		sResetClr,
		sFetch,
		sWait,
		sDecode,
		sSethi,
		sSethiWrite,
		sArith,
		sArithImm,
		sArithReg,
		sAluReady,
		sWrite,
		sPcAlu,
		sPcLoad
	} stateT;

	stateT state;
	stateT nextState;
	logic [5:0] baseOp3;
	logic isSethi;
	logic isArith;

	always_ff @(posedge Clk)
	begin
		if (RESET)
			state <= sResetClr;
		else
			state <= nextState;
	end

	// Same word seen as fmt2 for SETHI and as fmt3 for arithmetic
	always_comb
	begin
		baseOp3 = bus.ir.f3.op3;
		baseOp3[sparcPkg::ccBit] = 1'b0;
		isSethi = (bus.ir.f2.op == sparcPkg::opFmt2) && (bus.ir.f2.op2 == sparcPkg::op2Sethi);
		isArith = (bus.ir.f3.op == sparcPkg::opArith) &&
			(baseOp3 inside {sparcPkg::op3Add, sparcPkg::op3And, sparcPkg::op3Or,
			sparcPkg::op3Xor, sparcPkg::op3Sub});
	end

	always_comb
	begin
		nextState = state;
		bus.pcClr = 1'b0;
		bus.pcEnable = 1'b0;
		bus.npcEnable = 1'b0;
		bus.irEnable = 1'b0;
		bus.rfWrite = 1'b0;
		bus.pswEnable = 1'b0;
		memEnable = 1'b0;
		retireValid = 1'b0;
		retireIllegal = 1'b0;
		case (state)
			sResetClr:
			begin
				bus.pcClr = 1'b1;
				nextState = sFetch;
			end
			// PC settles on memAddr
			sFetch:
				nextState = sWait;
			sWait:
			begin
				memEnable = 1'b1;
				if (memMfc)
				begin
					bus.irEnable = 1'b1;
					nextState = sDecode;
				end
			end
			sDecode:
			begin
				if (isSethi)
					nextState = sSethi;
				else if (isArith)
					nextState = sArith;
				else
				begin
					// Illegal encodings retire straight from here
					retireValid = 1'b1;
					retireIllegal = 1'b1;
					nextState = sPcAlu;
				end
			end
			sSethi:
				nextState = sSethiWrite;
			sSethiWrite:
			begin
				bus.rfWrite = 1'b1;
				retireValid = 1'b1;
				nextState = sPcAlu;
			end
			sArith:
				nextState = bus.ir.f3.iBit ? sArithImm : sArithReg;
			sArithImm, sArithReg:
				nextState = sAluReady;
			sAluReady:
				nextState = sWrite;
			sWrite:
			begin
				bus.rfWrite = 1'b1;
				bus.pswEnable = bus.ir.f3.op3[sparcPkg::ccBit];
				retireValid = 1'b1;
				nextState = sPcAlu;
			end
			sPcAlu:
				nextState = sPcLoad;
			// NPC to PC, NPC + 4 to NPC
			sPcLoad:
			begin
				bus.pcEnable = 1'b1;
				bus.npcEnable = 1'b1;
				nextState = sWait;
			end
			default:
				nextState = sResetClr;
		endcase
	end

	// ALU steering is held from one state to the next
	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			bus.aluASel <= sparcPkg::aSelRs1;
			bus.aluBSel <= sparcPkg::bSelRs2;
			bus.aluOp <= sparcPkg::op3Add;
		end
		else
		begin
			case (state)
				sSethi:
				begin
					bus.aluASel <= sparcPkg::aSelRs1;
					bus.aluBSel <= sparcPkg::bSelSethi;
					bus.aluOp <= sparcPkg::op3Add;
				end
				sArith:
				begin
					bus.aluASel <= sparcPkg::aSelRs1;
					bus.aluOp <= bus.ir.f3.op3;
				end
				sArithImm:
					bus.aluBSel <= sparcPkg::bSelImm;
				sArithReg:
					bus.aluBSel <= sparcPkg::bSelRs2;
				sPcAlu:
				begin
					bus.aluASel <= sparcPkg::aSelNpc;
					bus.aluBSel <= sparcPkg::bSelFour;
					bus.aluOp <= sparcPkg::op3Add;
				end
				default:
				begin
				end
			endcase
		end
	end

endmodule

// ==== hw/ctrlIf.sv ====
`timescale 1ns/1ns

interface ctrlIf;

	// Register enables and clear
	logic pcEnable;
	logic npcEnable;
	logic irEnable;
	logic rfWrite;
	logic pswEnable;
	logic pcClr;

	// ALU steering
	logic [1:0] aluASel;
	logic [1:0] aluBSel;
	logic [5:0] aluOp;

	// Instruction register back to the FSM
	sparcPkg::instrWord ir;

	modport ctrl (
		output pcEnable, npcEnable, irEnable, rfWrite, pswEnable, pcClr,
		output aluASel, aluBSel, aluOp,
		input ir
	);

	modport dp (
		input pcEnable, npcEnable, irEnable, rfWrite, pswEnable, pcClr,
		input aluASel, aluBSel, aluOp,
		output ir
	);

endinterface

// ==== hw/datapath.sv ====
`timescale 1ns/1ns

module datapath
(
	input logic Clk,
	input logic RESET,
	ctrlIf.dp bus,
	input logic [31:0] memData,
	output logic [31:0] memAddr,
	output logic [31:0] retirePc,
	output logic [31:0] retireData,
	output logic [4:0] retireRd,
	output logic retireWrite,
	output sparcPkg::iccT retireIcc
);

	logic [31:0] pc;
	logic [31:0] npc;
	sparcPkg::instrWord irReg;
	sparcPkg::iccT psrIcc;
	sparcPkg::iccT aluIcc;
	logic [4:0] rs1Addr;
	logic [31:0] rs1Data;
	logic [31:0] rs2Data;
	logic [31:0] aluA;
	logic [31:0] aluB;
	logic [31:0] aluResult;

	always_ff @(posedge Clk)
	begin
		if (RESET || bus.pcClr)
		begin
			pc <= sparcPkg::resetPc;
			npc <= sparcPkg::resetPc + 32'd4;
		end
		else
		begin
			if (bus.pcEnable)
				pc <= npc;
			if (bus.npcEnable)
				npc <= aluResult;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (bus.irEnable)
			irReg <= memData;
	end

	always_ff @(posedge Clk)
	begin
		if (RESET)
			psrIcc <= '0;
		else if (bus.pswEnable)
			psrIcc <= aluIcc;
	end

	// SETHI adds onto register 0
	assign rs1Addr = (irReg.f3.op == sparcPkg::opArith) ? irReg.f3.rs1 : 5'd0;

	registerFile regFile (
		.Clk(Clk),
		.RESET(RESET),
		.rs1(rs1Addr),
		.rs2(irReg.f3.low13[4:0]),
		.rd(irReg.f3.rd),
		.write(bus.rfWrite),
		.wData(aluResult),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

	always_comb
	begin
		case (bus.aluASel)
			sparcPkg::aSelPc: aluA = pc;
			sparcPkg::aSelNpc: aluA = npc;
			default: aluA = rs1Data;
		endcase
		case (bus.aluBSel)
			sparcPkg::bSelImm: aluB = {{19{irReg.f3.low13[12]}}, irReg.f3.low13};
			sparcPkg::bSelFour: aluB = 32'd4;
			sparcPkg::bSelSethi: aluB = {irReg.f2.imm22, 10'd0};
			default: aluB = rs2Data;
		endcase
	end

	alu aluUnit (
		.op(bus.aluOp),
		.a(aluA),
		.b(aluB),
		.result(aluResult),
		.icc(aluIcc)
	);

	assign bus.ir = irReg;
	assign memAddr = pc;

	// Retire fields reflect the write-back cycle
	assign retirePc = pc;
	assign retireData = aluResult;
	assign retireRd = irReg.f3.rd;
	assign retireWrite = bus.rfWrite && (irReg.f3.rd != 5'd0);
	assign retireIcc = bus.pswEnable ? aluIcc : psrIcc;

endmodule

// ==== hw/registerFile.sv ====
`timescale 1ns/1ns

module registerFile
(
	input logic Clk,
	input logic RESET,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	input logic [4:0] rd,
	input logic write,
	input logic [31:0] wData,
	output logic [31:0] rs1Data,
	output logic [31:0] rs2Data
);

	logic [31:0] regs [32];

	// Register 0 never takes a write, so it reads as zero
	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (write && (rd != 5'd0))
			regs[rd] <= wData;
	end

	assign rs1Data = regs[rs1];
	assign rs2Data = regs[rs2];

endmodule

// ==== hw/sparcCore.sv ====
`timescale 1ns/1ns

module sparcCore
(
	input logic Clk,
	input logic RESET,
	input logic [31:0] memData,
	input logic memMfc,
	output logic [31:0] memAddr,
	output logic memEnable,
	output logic retireValid,
	output logic [31:0] retirePc,
	output logic retireWrite,
	output logic [4:0] retireRd,
	output logic [31:0] retireData,
	output sparcPkg::iccT retireIcc,
	output logic retireIllegal
);

	ctrlIf bus ();

	controlUnit ctrl (
		.Clk(Clk),
		.RESET(RESET),
		.bus(bus),
		.memMfc(memMfc),
		.memEnable(memEnable),
		.retireValid(retireValid),
		.retireIllegal(retireIllegal)
	);

	datapath dp (
		.Clk(Clk),
		.RESET(RESET),
		.bus(bus),
		.memData(memData),
		.memAddr(memAddr),
		.retirePc(retirePc),
		.retireData(retireData),
		.retireRd(retireRd),
		.retireWrite(retireWrite),
		.retireIcc(retireIcc)
	);

endmodule

// ==== hw/sparcPkg.sv ====
package sparcPkg;

	// Major opcode field
	localparam logic [1:0] opFmt2 = 2'b00;
	localparam logic [1:0] opArith = 2'b10;

	// op2 value of SETHI
	localparam logic [2:0] op2Sethi = 3'b100;

	// op3 values of the supported ALU operations
	localparam logic [5:0] op3Add = 6'b000000;
	localparam logic [5:0] op3And = 6'b000001;
	localparam logic [5:0] op3Or = 6'b000010;
	localparam logic [5:0] op3Xor = 6'b000011;
	localparam logic [5:0] op3Sub = 6'b000100;

	// Set in op3 for the cc variants
	localparam int ccBit = 4;

	// ALU input A choices
	localparam logic [1:0] aSelRs1 = 2'd0;
	localparam logic [1:0] aSelPc = 2'd1;
	localparam logic [1:0] aSelNpc = 2'd2;

	// ALU input B choices
	localparam logic [1:0] bSelRs2 = 2'd0;
	localparam logic [1:0] bSelImm = 2'd1;
	localparam logic [1:0] bSelFour = 2'd2;
	localparam logic [1:0] bSelSethi = 2'd3;

	localparam logic [31:0] resetPc = 32'h0000_0000;

	// Integer condition codes
	typedef struct packed {
		logic n;
		logic z;
		logic v;
		logic c;
	} iccT;

	// SETHI and branch layout
	typedef struct packed {
		logic [1:0] op;
		logic [4:0] rd;
		logic [2:0] op2;
		logic [21:0] imm22;
	} fmt2T;

	// Arithmetic layout, rs2 sits in the low bits of low13
	typedef struct packed {
		logic [1:0] op;
		logic [4:0] rd;
		logic [5:0] op3;
		logic [4:0] rs1;
		logic iBit;
		logic [12:0] low13;
	} fmt3T;

	typedef union packed {
		fmt2T f2;
		fmt3T f3;
	} instrWord;

endpackage

// ==== tb/sparcCoreAssert.sv ====
`timescale 1ns/1ns

module sparcCoreAssert
(
	input logic Clk,
	input logic RESET,
	input logic memEnable,
	input logic memMfc,
	input logic retireValid
);

	// Failed assertions so far
	int failCount = 0;

	// Fetch request held until the memory answers
	enableHeld: assert property (@(posedge Clk) disable iff (RESET)
		(memEnable && !memMfc) |=> memEnable)
	else
	begin
		failCount++;
		$error("memEnable dropped before memMfc");
	end

	retirePulse: assert property (@(posedge Clk) disable iff (RESET)
		retireValid |=> !retireValid)
	else
	begin
		failCount++;
		$error("retireValid lasted more than one cycle");
	end

	// No fetch while an instruction retires
	fetchOrRetire: assert property (@(posedge Clk) disable iff (RESET)
		!(memEnable && retireValid))
	else
	begin
		failCount++;
		$error("memEnable and retireValid high together");
	end

endmodule

bind sparcCore sparcCoreAssert handshakeChecks (
	.Clk(Clk),
	.RESET(RESET),
	.memEnable(memEnable),
	.memMfc(memMfc),
	.retireValid(retireValid)
);

// ==== tb/sparcCoreTb.sv ====
`timescale 1ns/1ns

module sparcCoreTb;

	localparam int numInstr = 64;

	logic Clk = 1'b0;
	logic RESET;
	logic [31:0] memData;
	logic memMfc;
	logic [31:0] memAddr;
	logic memEnable;
	logic retireValid;
	logic [31:0] retirePc;
	logic retireWrite;
	logic [4:0] retireRd;
	logic [31:0] retireData;
	sparcPkg::iccT retireIcc;
	logic retireIllegal;

	// Instruction-level model state
	sparcPkg::instrWord progMem [numInstr];
	logic [31:0] mRegs [32];
	logic [31:0] mPc;
	sparcPkg::iccT mIcc;

	// Expected retire of the instruction in flight
	logic expWrite;
	logic expIllegal;
	logic [31:0] expData;
	logic [4:0] expRd;
	int expLatency;

	sparcCore UUT (
		.Clk(Clk),
		.RESET(RESET),
		.memData(memData),
		.memMfc(memMfc),
		.memAddr(memAddr),
		.memEnable(memEnable),
		.retireValid(retireValid),
		.retirePc(retirePc),
		.retireWrite(retireWrite),
		.retireRd(retireRd),
		.retireData(retireData),
		.retireIcc(retireIcc),
		.retireIllegal(retireIllegal)
	);

	always #2 Clk = ~Clk;

	task automatic stopRun();
		$display("Checks failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic reportProblem(input string msg);
		$display("%0t: %s", $time, msg);
		stopRun();
	endtask

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkReg(input string name, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkIcc(input string name, input sparcPkg::iccT got,
		input sparcPkg::iccT exp);
		if (got !== exp)
		begin
			$display("FAIL %0t %s got NZVC=%b expected NZVC=%b", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
			stopRun();
		end
	endtask

	// Mostly SETHI and arithmetic, about one in ten illegal
	function automatic sparcPkg::instrWord randomInstr();
		sparcPkg::instrWord w;
		logic [5:0] ops [5];
		int pick;
		ops = '{sparcPkg::op3Add, sparcPkg::op3And, sparcPkg::op3Or,
			sparcPkg::op3Xor, sparcPkg::op3Sub};
		w = $urandom();
		pick = $urandom_range(0, 9);
		if (pick < 3)
		begin
			w.f2.op = sparcPkg::opFmt2;
			w.f2.op2 = sparcPkg::op2Sethi;
			w.f2.rd = $urandom_range(0, 7);
		end
		else if (pick < 9)
		begin
			w.f3.op = sparcPkg::opArith;
			w.f3.op3 = ops[$urandom_range(0, 4)];
			w.f3.op3[sparcPkg::ccBit] = $urandom_range(0, 1);
			w.f3.rd = $urandom_range(0, 7);
			w.f3.rs1 = $urandom_range(0, 7);
			// Small register range so results feed later operands
			if (!w.f3.iBit)
				w.f3.low13[4:0] = $urandom_range(0, 7);
		end
		else if ($urandom_range(0, 1))
			w.f2.op = 2'b11;
		else
		begin
			// Branch encoding, not supported
			w.f2.op = sparcPkg::opFmt2;
			w.f2.op2 = 3'b010;
		end
		return w;
	endfunction

	// Computes the expected retire and updates the model
	task automatic predict(input sparcPkg::instrWord w);
		logic [5:0] baseOp;
		logic [31:0] a;
		logic [31:0] b;
		longint trueResult;
		sparcPkg::iccT flags;
		logic legal;
		expRd = w.f3.rd;
		expWrite = 1'b0;
		expIllegal = 1'b0;
		expData = '0;
		expLatency = 1;
		legal = 1'b0;
		flags = '0;
		baseOp = w.f3.op3 & ~(6'd1 << sparcPkg::ccBit);
		if ((w.f2.op == sparcPkg::opFmt2) && (w.f2.op2 == sparcPkg::op2Sethi))
		begin
			expData = {10'd0, w.f2.imm22} << 10;
			expWrite = (w.f2.rd != 5'd0);
			expLatency = 3;
			legal = 1'b1;
		end
		else if (w.f3.op == sparcPkg::opArith)
		begin
			a = mRegs[w.f3.rs1];
			if (w.f3.iBit)
			begin
				// Two's complement value of simm13
				b = {19'd0, w.f3.low13};
				if (w.f3.low13[12])
					b = b - 32'h2000;
			end
			else
				b = mRegs[w.f3.low13[4:0]];
			legal = 1'b1;
			case (baseOp)
				sparcPkg::op3Add:
				begin
					expData = a + b;
					flags.c = (expData < a);
					trueResult = longint'($signed(a)) + longint'($signed(b));
					flags.v = (trueResult != longint'($signed(expData)));
				end
				sparcPkg::op3Sub:
				begin
					expData = a - b;
					flags.c = (a < b);
					trueResult = longint'($signed(a)) - longint'($signed(b));
					flags.v = (trueResult != longint'($signed(expData)));
				end
				sparcPkg::op3And:
					expData = a & b;
				sparcPkg::op3Or:
					expData = a | b;
				sparcPkg::op3Xor:
					expData = a ^ b;
				default:
					legal = 1'b0;
			endcase
			if (legal)
			begin
				flags.n = expData[31];
				flags.z = (expData == 32'd0);
				if (w.f3.op3[sparcPkg::ccBit])
					mIcc = flags;
				expWrite = (w.f3.rd != 5'd0);
				expLatency = 5;
			end
		end
		if (!legal)
		begin
			expIllegal = 1'b1;
			expData = '0;
		end
		if (expWrite)
			mRegs[expRd] = expData;
	endtask

	initial
	begin
		#(numInstr * 14 * 4 + 5 * 4);
		$display("%0t: watchdog expired, the core stopped retiring instructions", $time);
		stopRun();
	end

	// Bound handshake assertions
	always @(negedge Clk)
	begin
		if (UUT.handshakeChecks.failCount != 0)
			reportProblem("a handshake assertion failed");
	end

	initial
	begin
		int cycles;
		int delay;
		sparcPkg::instrWord fetched;
		void'($urandom(32'hc426));
		RESET = 1'b1;
		memMfc = 1'b0;
		memData = '0;
		mPc = sparcPkg::resetPc;
		mIcc = '0;
		for (int i = 0; i < 32; i++)
			mRegs[i] = '0;
		for (int i = 0; i < numInstr; i++)
			progMem[i] = randomInstr();

		repeat (5) @(posedge Clk);
		#1;
		RESET = 1'b0;

		cycles = 1;
		@(negedge Clk);
		while (!memEnable)
		begin
			cycles++;
			@(negedge Clk);
		end
		if (cycles > 3)
			reportProblem($sformatf("first fetch started %0d cycles after reset", cycles));

		for (int n = 0; n < numInstr; n++)
		begin
			checkWord("memAddr", memAddr, mPc);
			fetched = progMem[mPc[7:2]];
			predict(fetched);

			// Memory answers after a random delay
			delay = $urandom_range(1, 4);
			repeat (delay) @(posedge Clk);
			#1;
			memMfc = 1'b1;
			memData = fetched;
			@(posedge Clk);
			#1;
			memMfc = 1'b0;
			memData = $urandom();

			cycles = 1;
			@(negedge Clk);
			while (!retireValid)
			begin
				cycles++;
				@(negedge Clk);
			end
			if (cycles != expLatency)
				reportProblem($sformatf("retire came %0d cycles after memMfc instead of %0d",
					cycles, expLatency));

			checkWord("retirePc", retirePc, mPc);
			checkBit("retireIllegal", retireIllegal, expIllegal);
			checkBit("retireWrite", retireWrite, expWrite);
			if (expWrite)
			begin
				checkReg("retireRd", retireRd, expRd);
				checkWord("retireData", retireData, expData);
			end
			checkIcc("retireIcc", retireIcc, mIcc);
			mPc = mPc + 32'd4;

			// PC advance before the next fetch
			cycles = 1;
			@(negedge Clk);
			while (!memEnable)
			begin
				cycles++;
				@(negedge Clk);
			end
			if (cycles != 3)
				reportProblem($sformatf("next fetch came %0d cycles after retire instead of 3",
					cycles));
		end

		repeat (4) @(posedge Clk);
		if (UUT.handshakeChecks.failCount == 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
		begin
			$display("Checks failed");
			$fatal(1, "handshake assertions failed");
		end
	end

endmodule
